// ==== files.f ====
+incdir+common
common/mbox_pkg.sv
common/sync_pkg.sv
master_sync/mbox_decode.sv
master_sync/offset_execute.sv
master_sync/sync_result.sv
master_sync/master_sync_top.sv
tb/master_sync_chk.sv
tb/master_sync_tb.sv

// ==== Makefile ====
SRCS := $(wildcard common/*.sv common/*.svh master_sync/*.sv tb/*.sv)

.PHONY: run clean

run: obj_dir/Vmaster_sync_tb
	./obj_dir/Vmaster_sync_tb > sim.log 2>&1; cat sim.log
	@if grep -q "TEST FAILED" sim.log; then exit 1; fi
	@grep -q "TEST PASSED" sim.log

obj_dir/Vmaster_sync_tb: files.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module master_sync_tb -f files.f

clean:
	rm -rf obj_dir sim.log

// ==== tb/master_sync_tb.sv ====
`include "sync_config.svh"

module master_sync_tb;
	localparam int NODES = `SYNC_NODES;
	localparam int BASE = `LOPRI_BASE;
	localparam int LEN = `HIPRI_MSG_LEN;
	localparam int N_TESTS = 5;
	localparam int MAX_WRITES = 80; // Longest test fills the mailbox twice.
	localparam int WATCHDOG = N_TESTS * (MAX_WRITES + 40) * 10;

	logic clk_i;
	logic rst_n_i;
	logic rx_we_i;
	logic cycle_valid_i;
	logic cycle_ready_o;
	logic results_valid_o;
	mbox_pkg::mbox_addr_t rx_addr_i;
	mbox_pkg::mbox_byte_t rx_data_i;
	sync_pkg::stamp_t snapshot_tx_i;
	sync_pkg::stamp_t snapshot_rx_i;
	sync_pkg::node_vec_t rx_ok_o;
	sync_pkg::node_vec_t sync_ok_o;
	sync_pkg::node_vec_t slave_rdy_o;
	sync_pkg::node_vec_t scope_trig_o;
	sync_pkg::stamp_t comm_delay_o [NODES];
	sync_pkg::stamp_t clock_offset_o [NODES];

	logic [7:0] image [256]; // Mailbox as the DUT should see it.
	sync_pkg::node_vec_t m_lo;
	sync_pkg::node_vec_t m_hi;
	logic [31:0] lfsr;
	int cycle_no;
	int errors;
	int test_errors;
	int failed_tests;
	logic [31:0] exp_res_q [$];
	logic [4*NODES-1:0] exp_stat_q [$];
	int accept_q [$];

	master_sync_top uut (.*);

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	function automatic logic [31:0] take_bits(input int width);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < width; i++) begin
			lfsr = lfsr_next(lfsr);
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	function automatic logic [15:0] stamp_at(input int n, input int slot);
		return {image[BASE + n * LEN + 5 + 2 * slot], image[BASE + n * LEN + 4 + 2 * slot]};
	endfunction

	// {delay, offset} of node n.
	function automatic logic [31:0] ref_result(input int n);
		logic [15:0] a;
		logic [15:0] b;
		logic [15:0] c;
		logic [15:0] d;
		a = stamp_at(n, 0);
		b = stamp_at(n, 1);
		c = (n == 0) ? snapshot_tx_i : stamp_at(n - 1, 2);
		d = (n == 0) ? snapshot_rx_i : stamp_at(n - 1, 3);
		return {a - b - c + d, a + b - c - d};
	endfunction

	// {scope_trig, slave_rdy, sync_ok, rx_ok}.
	function automatic logic [4*NODES-1:0] ref_status();
		logic [4*NODES-1:0] s;
		logic ok;
		logic [7:0] f;
		s = '0;
		for (int n = 0; n < NODES; n++) begin
			ok = m_lo[n] & m_hi[n];
			f = image[BASE + n * LEN + 2];
			s[n] = ok;
			s[NODES + n] = ok & f[0];
			s[2 * NODES + n] = ok & f[0] & f[1];
			s[3 * NODES + n] = ok & f[2];
		end
		return s;
	endfunction

	task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
		assert (exp === act) else begin
			$display("mismatch at %0t: %s expected %h actual %h", $time, name, exp, act);
			errors++;
		end
	endtask

	task automatic mbox_write(input int addr, input logic [7:0] data);
		int n;
		int ofs;
		@(negedge clk_i);
		rx_we_i = 1'b1;
		rx_addr_i = mbox_pkg::mbox_addr_t'(addr);
		rx_data_i = data;
		image[addr] = data;
		n = (addr - BASE) / LEN;
		ofs = (addr - BASE) % LEN;
		// Node n counts only once node n-1 is complete.
		if (addr >= BASE && n < NODES && ofs >= 4 && ofs < 12 &&
			(n == 0 || (m_lo[n - 1] && m_hi[n - 1]))) begin
			if (ofs % 2 == 0)
				m_lo[n] = 1'b1;
			else if (m_lo[n])
				m_hi[n] = 1'b1;
		end
	endtask

	task automatic write_node(input int n, input logic with_low);
		int blk;
		blk = BASE + n * LEN;
		mbox_write(blk + 2, 8'(take_bits(8)));
		mbox_write(blk + 3, 8'(take_bits(8)));
		for (int k = 4; k < 12; k++)
			if (with_low || k % 2 == 1)
				mbox_write(blk + k, 8'(take_bits(8)));
	endtask

	task automatic accept_pending(input logic keep_valid);
		while (!cycle_ready_o)
			@(negedge clk_i);
		for (int n = 0; n < NODES; n++)
			exp_res_q.push_back(ref_result(n));
		exp_stat_q.push_back(ref_status());
		accept_q.push_back(cycle_no + 1);
		@(negedge clk_i);
		m_lo = '0; // Start clears receive bits and flags, stamps stay.
		m_hi = '0;
		for (int n = 0; n < NODES; n++) begin
			image[BASE + n * LEN + 2] = '0;
			image[BASE + n * LEN + 3] = '0;
		end
		cycle_valid_i = keep_valid;
	endtask

	task automatic start_cycle(input logic keep_valid);
		@(negedge clk_i);
		rx_we_i = 1'b0;
		snapshot_tx_i = sync_pkg::stamp_t'(take_bits(16));
		snapshot_rx_i = sync_pkg::stamp_t'(take_bits(16));
		cycle_valid_i = 1'b1;
		accept_pending(keep_valid);
	endtask

	task automatic wait_results();
		int n;
		n = 0;
		while (!results_valid_o && n < 40) begin
			@(negedge clk_i);
			n++;
		end
		assert (results_valid_o) else begin
			$display("error at %0t: results_valid_o did not rise within 40 cycles", $time);
			errors++;
		end
	endtask

	task automatic end_test(input int idx, input string name);
		@(negedge clk_i);
		assert (exp_stat_q.size() == 0) else begin
			$display("error at %0t: a cycle start produced no results", $time);
			errors++;
			exp_stat_q.delete();
			exp_res_q.delete();
			accept_q.delete();
		end
		$display("test %0d %s: %s, %0d errors", idx, name,
			(errors == test_errors) ? "ok" : "failed", errors - test_errors);
		if (errors != test_errors)
			failed_tests++;
		test_errors = errors;
	endtask

	initial begin
		clk_i = 1'b0;
		forever #5 clk_i = ~clk_i;
	end

	always @(posedge clk_i)
		cycle_no <= cycle_no + 1;

	// Compare on each results pulse.
	always @(negedge clk_i) begin
		logic [31:0] r;
		logic [4*NODES-1:0] st;
		int acc;
		if (rst_n_i && results_valid_o) begin
			assert (exp_stat_q.size() != 0) else begin
				$display("error at %0t: results_valid_o without a pending cycle start", $time);
				errors++;
			end
			if (exp_stat_q.size() != 0) begin
				st = exp_stat_q.pop_front();
				acc = accept_q.pop_front();
				check_value("results_valid_o latency", 5 * NODES, cycle_no - acc);
				for (int n = 0; n < NODES; n++) begin
					r = exp_res_q.pop_front();
					check_value($sformatf("comm_delay_o[%0d]", n), r[31:16], comm_delay_o[n]);
					check_value($sformatf("clock_offset_o[%0d]", n), r[15:0], clock_offset_o[n]);
				end
				check_value("{scope_trig_o, slave_rdy_o, sync_ok_o, rx_ok_o}", st,
					{scope_trig_o, slave_rdy_o, sync_ok_o, rx_ok_o});
			end
		end
	end

	initial begin
		#(WATCHDOG);
		$display("timeout: run did not finish within %0d time units", WATCHDOG);
		$display("TEST FAILED");
		$finish;
	end

	initial begin
		lfsr = 32'h20b0_bb4a;
		cycle_no = 0;
		errors = 0;
		test_errors = 0;
		failed_tests = 0;
		rst_n_i = 1'b0;
		rx_we_i = 1'b0;
		rx_addr_i = '0;
		rx_data_i = '0;
		cycle_valid_i = 1'b0;
		snapshot_tx_i = '0;
		snapshot_rx_i = '0;
		m_lo = '0;
		m_hi = '0;
		for (int i = 0; i < 256; i++)
			image[i] = '0;
		repeat (5) @(negedge clk_i);
		rst_n_i = 1'b1;

		@(negedge clk_i);
		check_value("cycle_ready_o", 1, cycle_ready_o);
		check_value("results_valid_o", 0, results_valid_o);
		check_value("{scope_trig_o, slave_rdy_o, sync_ok_o, rx_ok_o}", 0,
			{scope_trig_o, slave_rdy_o, sync_ok_o, rx_ok_o});
		for (int n = 0; n < NODES; n++) begin
			check_value($sformatf("comm_delay_o[%0d]", n), 0, comm_delay_o[n]);
			check_value($sformatf("clock_offset_o[%0d]", n), 0, clock_offset_o[n]);
		end
		end_test(1, "reset state");

		for (int n = 0; n < NODES; n++)
			write_node(n, 1'b1);
		start_cycle(1'b0);
		wait_results();
		end_test(2, "full write");

		// Last node lacks its low bytes.
		for (int n = 0; n < NODES; n++)
			write_node(n, n != NODES - 1);
		start_cycle(1'b0);
		wait_results();
		end_test(3, "status flags");

		write_node(1, 1'b1);
		write_node(0, 1'b1);
		for (int n = 2; n < NODES; n++)
			write_node(n, 1'b1);
		start_cycle(1'b0);
		wait_results();
		write_node(0, 1'b0); // High bytes only.
		for (int k = 4; k < 12; k += 2)
			mbox_write(BASE + k, 8'(take_bits(8))); // Low bytes come too late.
		for (int n = 1; n < NODES; n++)
			write_node(n, 1'b1);
		start_cycle(1'b0);
		wait_results();
		end_test(4, "receive order");

		for (int n = 0; n < NODES; n++)
			write_node(n, 1'b1);
		start_cycle(1'b1);
		wait_results();
		accept_pending(1'b0); // Held valid is taken once ready returns.
		wait_results();
		for (int n = 0; n < NODES; n++)
			write_node(n, 1'b1);
		start_cycle(1'b0);
		wait_results();
		end_test(5, "back-pressure");

		$display("summary: %0d tests, %0d failed, %0d errors", N_TESTS, failed_tests, errors);
		if (errors == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

// ==== tb/master_sync_chk.sv ====
`include "sync_config.svh"

module master_sync_chk (
	input logic clk_i,
	input logic rst_n_i,
	input logic valid_i,
	input logic ready_i,
	input logic done_i
);
	localparam int RUN_CYCLES = 5 * `SYNC_NODES;

	int busy_left;

	// Edges left before ready may return.
	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i)
			busy_left <= 0;
		else if (valid_i && ready_i)
			busy_left <= RUN_CYCLES;
		else if (busy_left != 0)
			busy_left <= busy_left - 1;
	end

	ready_after_reset: assert property (@(posedge clk_i) !rst_n_i |=> ready_i)
		else $error("cycle_ready_o low in the cycle after reset");

	done_one_cycle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		done_i |=> !done_i)
		else $error("results_valid_o high for more than one cycle");

	ready_low_while_busy: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		busy_left != 0 |-> !ready_i)
		else $error("cycle_ready_o high during the computation");

	ready_returns: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		busy_left == 1 |=> ready_i)
		else $error("cycle_ready_o did not return after the last node");

endmodule

bind master_sync_top master_sync_chk u_chk (
	.clk_i   (clk_i),
	.rst_n_i (rst_n_i),
	.valid_i (cycle_valid_i),
	.ready_i (cycle_ready_o),
	.done_i  (results_valid_o)
);

// ==== master_sync/master_sync_top.sv ====
`include "sync_config.svh"

module master_sync_top (
	input  logic                 clk_i,
	input  logic                 rst_n_i,
	input  logic                 rx_we_i,
	input  mbox_pkg::mbox_addr_t rx_addr_i,
	input  mbox_pkg::mbox_byte_t rx_data_i,
	input  logic                 cycle_valid_i,
	input  sync_pkg::stamp_t     snapshot_tx_i,
	input  sync_pkg::stamp_t     snapshot_rx_i,
	output logic                 cycle_ready_o,
	output logic                 results_valid_o,
	output sync_pkg::node_vec_t  rx_ok_o,
	output sync_pkg::node_vec_t  sync_ok_o,
	output sync_pkg::node_vec_t  slave_rdy_o,
	output sync_pkg::node_vec_t  scope_trig_o,
	output sync_pkg::stamp_t     comm_delay_o [`SYNC_NODES],
	output sync_pkg::stamp_t     clock_offset_o [`SYNC_NODES]
);
	logic                  accept;
	logic                  busy;
	mbox_pkg::stamp_addr_t rd_addr;
	sync_pkg::stamp_t      rd_stamp;
	sync_pkg::node_vec_t   dec_rx_ok;
	sync_pkg::node_vec_t   flag_sync;
	sync_pkg::node_vec_t   flag_slave;
	sync_pkg::node_vec_t   flag_trig;
	logic                  res_we;
	sync_pkg::node_t       res_node;
	sync_pkg::stamp_t      res_delay;
	sync_pkg::stamp_t      res_offset;

	assign accept = cycle_valid_i && !busy; // Valid is ignored while busy.
	assign cycle_ready_o = !busy;

	mbox_decode u_decode (
		.clk_i        (clk_i),
		.rst_n_i      (rst_n_i),
		.rx_we_i      (rx_we_i),
		.rx_addr_i    (rx_addr_i),
		.rx_data_i    (rx_data_i),
		.clear_i      (accept),
		.rd_addr_i    (rd_addr),
		.rd_stamp_o   (rd_stamp),
		.rx_ok_o      (dec_rx_ok),
		.flag_sync_o  (flag_sync),
		.flag_slave_o (flag_slave),
		.flag_trig_o  (flag_trig)
	);

	offset_execute u_execute (
		.clk_i        (clk_i),
		.rst_n_i      (rst_n_i),
		.start_i      (accept),
		.snap_tx_i    (snapshot_tx_i),
		.snap_rx_i    (snapshot_rx_i),
		.rd_stamp_i   (rd_stamp),
		.busy_o       (busy),
		.rd_addr_o    (rd_addr),
		.res_we_o     (res_we),
		.res_node_o   (res_node),
		.res_delay_o  (res_delay),
		.res_offset_o (res_offset),
		.done_o       (results_valid_o)
	);

	sync_result u_result (
		.clk_i          (clk_i),
		.rst_n_i        (rst_n_i),
		.latch_i        (accept),
		.rx_ok_i        (dec_rx_ok),
		.flag_sync_i    (flag_sync),
		.flag_slave_i   (flag_slave),
		.flag_trig_i    (flag_trig),
		.res_we_i       (res_we),
		.res_node_i     (res_node),
		.res_delay_i    (res_delay),
		.res_offset_i   (res_offset),
		.rx_ok_o        (rx_ok_o),
		.sync_ok_o      (sync_ok_o),
		.slave_rdy_o    (slave_rdy_o),
		.scope_trig_o   (scope_trig_o),
		.comm_delay_o   (comm_delay_o),
		.clock_offset_o (clock_offset_o)
	);

endmodule

// ==== master_sync/sync_result.sv ====
`include "sync_config.svh"

module sync_result (
	input  logic                clk_i,
	input  logic                rst_n_i,
	input  logic                latch_i,
	input  sync_pkg::node_vec_t rx_ok_i,
	input  sync_pkg::node_vec_t flag_sync_i,
	input  sync_pkg::node_vec_t flag_slave_i,
	input  sync_pkg::node_vec_t flag_trig_i,
	input  logic                res_we_i,
	input  sync_pkg::node_t     res_node_i,
	input  sync_pkg::stamp_t    res_delay_i,
	input  sync_pkg::stamp_t    res_offset_i,
	output sync_pkg::node_vec_t rx_ok_o,
	output sync_pkg::node_vec_t sync_ok_o,
	output sync_pkg::node_vec_t slave_rdy_o,
	output sync_pkg::node_vec_t scope_trig_o,
	output sync_pkg::stamp_t    comm_delay_o [`SYNC_NODES],
	output sync_pkg::stamp_t    clock_offset_o [`SYNC_NODES]
);
	// Status snapshot taken at cycle start.
	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			rx_ok_o <= '0;
			sync_ok_o <= '0;
			slave_rdy_o <= '0;
			scope_trig_o <= '0;
		end else if (latch_i) begin
			rx_ok_o <= rx_ok_i;
			sync_ok_o <= rx_ok_i & flag_sync_i;
			slave_rdy_o <= rx_ok_i & flag_sync_i & flag_slave_i;
			scope_trig_o <= rx_ok_i & flag_trig_i; // Trigger does not need sync.
		end
	end

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			for (int n = 0; n < `SYNC_NODES; n++) begin
				comm_delay_o[n] <= '0;
				clock_offset_o[n] <= '0;
			end
		end else if (res_we_i) begin
			comm_delay_o[res_node_i] <= res_delay_i;
			clock_offset_o[res_node_i] <= res_offset_i;
		end
	end

endmodule

// ==== master_sync/offset_execute.sv ====
module offset_execute (
	input  logic                  clk_i,
	input  logic                  rst_n_i,
	input  logic                  start_i,
	input  sync_pkg::stamp_t      snap_tx_i,
	input  sync_pkg::stamp_t      snap_rx_i,
	input  sync_pkg::stamp_t      rd_stamp_i,
	output logic                  busy_o,
	output mbox_pkg::stamp_addr_t rd_addr_o,
	output logic                  res_we_o,
	output sync_pkg::node_t       res_node_o,
	output sync_pkg::stamp_t      res_delay_o,
	output sync_pkg::stamp_t      res_offset_o,
	output logic                  done_o
);
	typedef enum logic [2:0] {
		S_IDLE,
		S_1,
		S_2,
		S_3,
		S_4,
		S_5
	} state_t;

	state_t           state;
	sync_pkg::node_t  node;
	sync_pkg::node_t  prev_node;
	sync_pkg::stamp_t snap_tx_q;
	sync_pkg::stamp_t snap_rx_q;
	sync_pkg::stamp_t opnd;
	sync_pkg::stamp_t acc_delay;
	sync_pkg::stamp_t acc_offset;

	assign prev_node = node - 1'b1;

	always_comb begin
		case (state)
			S_1: rd_addr_o = {node, mbox_pkg::SLOT_A};
			S_2: rd_addr_o = {node, mbox_pkg::SLOT_B};
			S_3: rd_addr_o = {prev_node, mbox_pkg::SLOT_C};
			S_4: rd_addr_o = {prev_node, mbox_pkg::SLOT_D};
			default: rd_addr_o = {node, mbox_pkg::SLOT_A};
		endcase
	end

	// Node 0 pairs with the master's own snapshots.
	always_comb begin
		if (node == '0 && state == S_3)
			opnd = snap_tx_q;
		else if (node == '0 && state == S_4)
			opnd = snap_rx_q;
		else
			opnd = rd_stamp_i;
	end

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state <= S_IDLE;
			node <= '0;
			done_o <= 1'b0;
		end else begin
			done_o <= 1'b0;
			case (state)
				S_IDLE: begin
					node <= '0;
					if (start_i)
						state <= S_1;
				end
				S_1: state <= S_2;
				S_2: state <= S_3;
				S_3: state <= S_4;
				S_4: state <= S_5;
				S_5: begin
					node <= node + 1'b1;
					if (node == sync_pkg::LAST_NODE) begin
						state <= S_IDLE;
						done_o <= 1'b1;
					end else begin
						state <= S_1;
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk_i) begin
		if (state == S_IDLE && start_i) begin
			snap_tx_q <= snap_tx_i;
			snap_rx_q <= snap_rx_i;
		end
		case (state)
			S_1: begin
				acc_delay <= opnd; // Fresh start per node.
				acc_offset <= opnd;
			end
			S_2: begin
				acc_delay <= acc_delay - opnd;
				acc_offset <= acc_offset + opnd;
			end
			S_3: begin
				acc_delay <= acc_delay - opnd;
				acc_offset <= acc_offset - opnd;
			end
			S_4: begin
				acc_delay <= acc_delay + opnd;
				acc_offset <= acc_offset - opnd;
			end
			default: ;
		endcase
	end

	assign busy_o = (state != S_IDLE);
	assign res_we_o = (state == S_5);
	assign res_node_o = node;
	assign res_delay_o = acc_delay;
	assign res_offset_o = acc_offset;

endmodule

// ==== master_sync/mbox_decode.sv ====
`include "sync_config.svh"

module mbox_decode (
	input  logic                  clk_i,
	input  logic                  rst_n_i,
	input  logic                  rx_we_i,
	input  mbox_pkg::mbox_addr_t  rx_addr_i,
	input  mbox_pkg::mbox_byte_t  rx_data_i,
	input  logic                  clear_i,
	input  mbox_pkg::stamp_addr_t rd_addr_i,
	output sync_pkg::stamp_t      rd_stamp_o,
	output sync_pkg::node_vec_t   rx_ok_o,
	output sync_pkg::node_vec_t   flag_sync_o,
	output sync_pkg::node_vec_t   flag_slave_o,
	output sync_pkg::node_vec_t   flag_trig_o
);
	localparam int STAMP_ENTRIES = `SYNC_NODES * mbox_pkg::STAMP_SLOTS;
	localparam mbox_pkg::mbox_addr_t BASE = mbox_pkg::mbox_addr_t'(`LOPRI_BASE);
	localparam mbox_pkg::mbox_addr_t SPAN = mbox_pkg::mbox_addr_t'(`SYNC_NODES * `HIPRI_MSG_LEN);
	localparam mbox_pkg::mbox_addr_t MSG_LEN = mbox_pkg::mbox_addr_t'(`HIPRI_MSG_LEN);

	mbox_pkg::mbox_addr_t  rel_addr;
	mbox_pkg::mbox_addr_t  byte_ofs;
	sync_pkg::node_t       wr_node;
	mbox_pkg::stamp_addr_t wr_addr;
	logic                  in_block;
	logic                  is_stamp;
	logic                  prev_ok;
	sync_pkg::node_vec_t   rx_lo;
	sync_pkg::node_vec_t   rx_hi;
	sync_pkg::node_flags_t flags [`SYNC_NODES];
	mbox_pkg::mbox_byte_t  stamp_lo [STAMP_ENTRIES];
	mbox_pkg::mbox_byte_t  stamp_hi [STAMP_ENTRIES];

	assign rel_addr = rx_addr_i - BASE;
	assign in_block = (rx_addr_i >= BASE) && (rel_addr < SPAN);
	assign wr_node = sync_pkg::node_t'(rel_addr / MSG_LEN);
	assign byte_ofs = rel_addr % MSG_LEN;
	assign is_stamp = in_block && (byte_ofs >= mbox_pkg::STAMP_OFS) &&
		(byte_ofs < mbox_pkg::STAMP_END_OFS);
	assign wr_addr = {wr_node, mbox_pkg::slot_t'((byte_ofs - mbox_pkg::STAMP_OFS) >> 1)};

	// Node n only counts once node n-1 is complete.
	assign prev_ok = (wr_node == '0) || (rx_lo[wr_node - 1'b1] && rx_hi[wr_node - 1'b1]);

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			rx_lo <= '0;
			rx_hi <= '0;
			for (int n = 0; n < `SYNC_NODES; n++)
				flags[n] <= '0;
			for (int i = 0; i < STAMP_ENTRIES; i++) begin
				stamp_lo[i] <= '0;
				stamp_hi[i] <= '0;
			end
		end else begin
			if (rx_we_i && is_stamp) begin
				if (byte_ofs[0])
					stamp_hi[wr_addr] <= rx_data_i;
				else
					stamp_lo[wr_addr] <= rx_data_i;
			end
			if (clear_i) begin
				rx_lo <= '0;
				rx_hi <= '0;
				for (int n = 0; n < `SYNC_NODES; n++)
					flags[n] <= '0;
			end else if (rx_we_i && in_block) begin
				if (is_stamp && prev_ok) begin
					if (!byte_ofs[0])
						rx_lo[wr_node] <= 1'b1;
					else if (rx_lo[wr_node])
						rx_hi[wr_node] <= 1'b1; // High byte needs its low byte first.
				end
				if (byte_ofs == mbox_pkg::FLAGS_LO_OFS)
					flags[wr_node][7:0] <= rx_data_i;
				if (byte_ofs == mbox_pkg::FLAGS_HI_OFS)
					flags[wr_node][15:8] <= rx_data_i;
			end
		end
	end

	always_comb begin
		for (int n = 0; n < `SYNC_NODES; n++) begin
			flag_sync_o[n] = flags[n][sync_pkg::FLAG_SYNC];
			flag_slave_o[n] = flags[n][sync_pkg::FLAG_SLAVE];
			flag_trig_o[n] = flags[n][sync_pkg::FLAG_TRIG];
		end
	end

	assign rx_ok_o = rx_lo & rx_hi;
	assign rd_stamp_o = {stamp_hi[rd_addr_i], stamp_lo[rd_addr_i]};

endmodule

// ==== common/sync_pkg.sv ====
`include "sync_config.svh"

package sync_pkg;

	typedef logic [`SYNC_NODE_W-1:0] node_t;

	// Timestamps, delays and offsets all wrap modulo 2^16.
	typedef logic [`STAMP_W-1:0] stamp_t;

	typedef logic [`SYNC_NODES-1:0] node_vec_t;

	typedef logic [15:0] node_flags_t;

	// Bit positions in node_flags_t.
	localparam int FLAG_SYNC = 0;
	localparam int FLAG_SLAVE = 1;
	localparam int FLAG_TRIG = 2;

	localparam node_t LAST_NODE = node_t'(`SYNC_NODES - 1);

endpackage

// ==== common/mbox_pkg.sv ====
`include "sync_config.svh"

package mbox_pkg;

	typedef logic [`PTR_W-1:0] mbox_addr_t;
	typedef logic [7:0] mbox_byte_t;

	// Stamp slot inside one node block.
	typedef logic [1:0] slot_t;

	// {node, slot} index into the stamp memories.
	typedef logic [`SYNC_NODE_W+1:0] stamp_addr_t;

	localparam int STAMP_SLOTS = 4;

	// Byte offsets inside a node block.
	localparam mbox_addr_t FLAGS_LO_OFS = 2;
	localparam mbox_addr_t FLAGS_HI_OFS = 3;
	localparam mbox_addr_t STAMP_OFS = 4; // Low byte of slot 0.
	localparam mbox_addr_t STAMP_END_OFS = 12; // One past the last stamp byte.

	// Slot 0 and 1 are the node's own stamps, 2 and 3 are read back by the next node.
	localparam slot_t SLOT_A = 2'd0;
	localparam slot_t SLOT_B = 2'd1;
	localparam slot_t SLOT_C = 2'd2;
	localparam slot_t SLOT_D = 2'd3;

endpackage

// ==== common/sync_config.svh ====
`ifndef SYNC_CONFIG_SVH
`define SYNC_CONFIG_SVH

// High-priority nodes on the bus.
`define SYNC_NODES 4
`define SYNC_NODE_W 2

// Bytes in one node message block.
`define HIPRI_MSG_LEN 16

// First high-priority mailbox address.
`define LOPRI_BASE 32

// Mailbox address width.
`define PTR_W 8

// Timestamp, delay and offset width.
`define STAMP_W 16

`endif
